//--- csr_stage.f
+incdir+tests
source/csr_pkg.sv
source/csr_decode.sv
source/csr_file.sv
source/trap_ctrl.sv
source/csr_stage.sv
tests/csr_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CSR stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=csr_stage_sim

verilator --binary --timing --assert -Wno-fatal \
    -f csr_stage.f --top-module csr_stage_tb -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

//--- source/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
    input  logic                req_valid,
    input  csr_pkg::csr_cmd_e   req_cmd,
    input  csr_pkg::csr_addr_t  req_addr,
    input  csr_pkg::xlen_t      req_operand,
    input  csr_pkg::xlen_t      rdata,
    input  csr_pkg::priv_e      priv,
    output logic                illegal,
    output logic                write_req,
    output csr_pkg::xlen_t      wdata
);

    logic is_csr_cmd;
    logic implemented;
    logic priv_ok;
    logic read_only;
    logic access_bad;

    // Address bits 9:8 give the lowest mode allowed, 11:10 == 3 marks read-only
    always_comb begin
        is_csr_cmd = (req_cmd == csr_pkg::CMD_W) || (req_cmd == csr_pkg::CMD_S) ||
                     (req_cmd == csr_pkg::CMD_C);

        case (req_addr)
            csr_pkg::ADDR_MSTATUS,
            csr_pkg::ADDR_MISA,
            csr_pkg::ADDR_MIE,
            csr_pkg::ADDR_MTVEC,
            csr_pkg::ADDR_MSCRATCH,
            csr_pkg::ADDR_MEPC,
            csr_pkg::ADDR_MCAUSE,
            csr_pkg::ADDR_MIP,
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLE,
            csr_pkg::ADDR_CYCLEH: implemented = 1'b1;
            default:              implemented = 1'b0;
        endcase

        priv_ok    = req_addr[9:8] <= 2'(priv);
        read_only  = req_addr[11:10] == 2'b11;

        // S and C with a zero operand still count as writes
        access_bad = !priv_ok || read_only || !implemented;

        illegal    = req_valid && is_csr_cmd && access_bad;
        write_req  = req_valid && is_csr_cmd && !access_bad;
    end

    // New value from the operand and the current contents
    always_comb begin
        case (req_cmd)
            csr_pkg::CMD_W: wdata = req_operand;
            csr_pkg::CMD_S: wdata = rdata | req_operand;
            csr_pkg::CMD_C: wdata = rdata & ~req_operand;
            default:        wdata = '0;
        endcase
    end

endmodule

//--- source/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter int CYCLE_W = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  csr_pkg::csr_addr_t  req_addr,
    input  csr_pkg::xlen_t      req_pc,
    input  logic                write_req,
    input  csr_pkg::xlen_t      wdata,
    input  logic                take_trap,
    input  csr_pkg::xlen_t      trap_cause,
    input  logic                do_mret,
    input  logic                irq_ext,
    input  logic                irq_timer,
    output csr_pkg::xlen_t      rdata,
    output csr_pkg::xlen_t      rsp_rdata,
    output csr_pkg::priv_e      priv,
    output logic                mstatus_mie,
    output csr_pkg::xlen_t      mie_bits,
    output csr_pkg::xlen_t      mip_bits,
    output csr_pkg::xlen_t      mtvec,
    output csr_pkg::xlen_t      mepc
);

    csr_pkg::priv_e     mode_q;
    csr_pkg::priv_e     mpp_q;
    logic               mie_q;
    logic               mpie_q;
    logic               mie_mei_q;
    logic               mie_mti_q;
    csr_pkg::xlen_t     mtvec_q;
    csr_pkg::xlen_t     mscratch_q;
    csr_pkg::xlen_t     mepc_q;
    csr_pkg::xlen_t     mcause_q;
    logic [CYCLE_W-1:0] cycle_q;
    logic [CYCLE_W-1:0] cycle_base;
    logic [63:0]        cycle_ext;
    csr_pkg::xlen_t     mstatus_word;
    logic               apply_write;

    // Trap entry takes the place of the CSR write
    assign apply_write = write_req && !take_trap;

    // Upper half reads zero with a 32-bit counter
    assign cycle_ext = 64'(cycle_q);

    always_comb begin
        mstatus_word = '0;
        mstatus_word[csr_pkg::MSTATUS_MIE_BIT]  = mie_q;
        mstatus_word[csr_pkg::MSTATUS_MPIE_BIT] = mpie_q;
        mstatus_word[csr_pkg::MSTATUS_MPP_MSB:csr_pkg::MSTATUS_MPP_LSB] = mpp_q;

        mie_bits = '0;
        mie_bits[csr_pkg::IRQ_MEI_BIT] = mie_mei_q;
        mie_bits[csr_pkg::IRQ_MTI_BIT] = mie_mti_q;

        // mip follows the platform lines directly
        mip_bits = '0;
        mip_bits[csr_pkg::IRQ_MEI_BIT] = irq_ext;
        mip_bits[csr_pkg::IRQ_MTI_BIT] = irq_timer;
    end

    always_comb begin
        case (req_addr)
            csr_pkg::ADDR_MSTATUS:  rdata = mstatus_word;
            csr_pkg::ADDR_MISA:     rdata = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MIE:      rdata = mie_bits;
            csr_pkg::ADDR_MTVEC:    rdata = mtvec_q;
            csr_pkg::ADDR_MSCRATCH: rdata = mscratch_q;
            csr_pkg::ADDR_MEPC:     rdata = mepc_q;
            csr_pkg::ADDR_MCAUSE:   rdata = mcause_q;
            csr_pkg::ADDR_MIP:      rdata = mip_bits;
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:    rdata = cycle_ext[31:0];
            csr_pkg::ADDR_MCYCLEH,
            csr_pkg::ADDR_CYCLEH:   rdata = cycle_ext[63:32];
            default:                rdata = '0;
        endcase
    end

    // Old value goes back with the response
    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_rdata <= rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q     <= csr_pkg::PRIV_M;
            mpp_q      <= csr_pkg::PRIV_U;
            mie_q      <= 1'b0;
            mpie_q     <= 1'b0;
            mie_mei_q  <= 1'b0;
            mie_mti_q  <= 1'b0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (take_trap) begin
            mepc_q   <= req_pc;
            mcause_q <= trap_cause;
            mpie_q   <= mie_q;
            mie_q    <= 1'b0;
            mpp_q    <= mode_q;
            mode_q   <= csr_pkg::PRIV_M;
        end else if (do_mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
            mode_q <= mpp_q;
            mpp_q  <= csr_pkg::PRIV_U;
        end else if (apply_write) begin
            case (req_addr)
                csr_pkg::ADDR_MSTATUS: begin
                    mie_q  <= wdata[csr_pkg::MSTATUS_MIE_BIT];
                    mpie_q <= wdata[csr_pkg::MSTATUS_MPIE_BIT];
                    // MPP keeps only legal modes
                    mpp_q  <= (wdata[csr_pkg::MSTATUS_MPP_MSB:csr_pkg::MSTATUS_MPP_LSB] == 2'b11)
                              ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
                end
                csr_pkg::ADDR_MIE: begin
                    mie_mei_q <= wdata[csr_pkg::IRQ_MEI_BIT];
                    mie_mti_q <= wdata[csr_pkg::IRQ_MTI_BIT];
                end
                // Modes 2 and 3 are reserved, so bit 1 stays zero
                csr_pkg::ADDR_MTVEC:    mtvec_q    <= {wdata[31:2], 1'b0, wdata[0]};
                csr_pkg::ADDR_MSCRATCH: mscratch_q <= wdata;
                csr_pkg::ADDR_MEPC:     mepc_q     <= {wdata[31:2], 2'b00};
                csr_pkg::ADDR_MCAUSE:   mcause_q   <= wdata;
                default: ;
            endcase
        end
    end

    // Counter write merges into the half being written
    always_comb begin
        cycle_base = cycle_q;
        if (apply_write && (req_addr == csr_pkg::ADDR_MCYCLE)) begin
            cycle_base = CYCLE_W'({cycle_ext[63:32], wdata});
        end else if (apply_write && (req_addr == csr_pkg::ADDR_MCYCLEH)) begin
            cycle_base = CYCLE_W'({wdata, cycle_ext[31:0]});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_base + 1'b1;
        end
    end

    assign priv        = mode_q;
    assign mstatus_mie = mie_q;
    assign mtvec       = mtvec_q;
    assign mepc        = mepc_q;

    assert property (@(posedge clk) disable iff (!rst_n) !(take_trap && do_mret))
        else $error("csr_file: trap entry and MRET in the same cycle");

endmodule

//--- source/csr_pkg.sv
package csr_pkg;

    // Data word and CSR address
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    // Only user and machine mode exist
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    // Machine trap setup
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    // Counters, machine copy and user read-only copy
    localparam csr_addr_t ADDR_MCYCLE   = 12'hB00;
    localparam csr_addr_t ADDR_MCYCLEH  = 12'hB80;
    localparam csr_addr_t ADDR_CYCLE    = 12'hC00;
    localparam csr_addr_t ADDR_CYCLEH   = 12'hC80;

    // Exception causes
    localparam xlen_t CAUSE_ILLEGAL = 32'd2;
    localparam xlen_t CAUSE_ECALL_U = 32'd8;
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

    // Interrupt causes carry bit 31
    localparam xlen_t CAUSE_M_TIMER = 32'h8000_0007;
    localparam xlen_t CAUSE_M_EXT   = 32'h8000_000B;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MSTATUS_MPP_MSB  = 12;

    // Shared by mie and mip
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

    // MXL = 1, extensions I, M and U
    localparam xlen_t MISA_VALUE = 32'h4010_1100;

endpackage

//--- source/csr_stage.sv
`timescale 1ns/1ps

module csr_stage #(
    parameter int CYCLE_W = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  csr_pkg::csr_cmd_e   req_cmd,
    input  csr_pkg::csr_addr_t  req_addr,
    input  csr_pkg::xlen_t      req_operand,
    input  csr_pkg::xlen_t      req_pc,
    input  logic                irq_ext,
    input  logic                irq_timer,
    output logic                rsp_valid,
    output csr_pkg::xlen_t      rsp_rdata,
    output logic                rsp_trap,
    output logic                rsp_redirect,
    output csr_pkg::xlen_t      rsp_target,
    output csr_pkg::priv_e      priv
);

    csr_pkg::xlen_t rdata;
    csr_pkg::xlen_t wdata;
    csr_pkg::xlen_t trap_cause;
    csr_pkg::xlen_t mie_bits;
    csr_pkg::xlen_t mip_bits;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mepc;
    logic           illegal;
    logic           write_req;
    logic           take_trap;
    logic           do_mret;
    logic           mstatus_mie;

    // Legality and write value
    csr_decode u_decode (
        .req_valid   (req_valid),
        .req_cmd     (req_cmd),
        .req_addr    (req_addr),
        .req_operand (req_operand),
        .rdata       (rdata),
        .priv        (priv),
        .illegal     (illegal),
        .write_req   (write_req),
        .wdata       (wdata)
    );

    // Architectural state and cycle counter
    csr_file #(
        .CYCLE_W (CYCLE_W)
    ) u_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_pc      (req_pc),
        .write_req   (write_req),
        .wdata       (wdata),
        .take_trap   (take_trap),
        .trap_cause  (trap_cause),
        .do_mret     (do_mret),
        .irq_ext     (irq_ext),
        .irq_timer   (irq_timer),
        .rdata       (rdata),
        .rsp_rdata   (rsp_rdata),
        .priv        (priv),
        .mstatus_mie (mstatus_mie),
        .mie_bits    (mie_bits),
        .mip_bits    (mip_bits),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    // Trap decision and response flags
    trap_ctrl u_trap (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_cmd      (req_cmd),
        .req_pc       (req_pc),
        .illegal      (illegal),
        .priv         (priv),
        .mstatus_mie  (mstatus_mie),
        .mie_bits     (mie_bits),
        .mip_bits     (mip_bits),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .take_trap    (take_trap),
        .trap_cause   (trap_cause),
        .do_mret      (do_mret),
        .rsp_valid    (rsp_valid),
        .rsp_trap     (rsp_trap),
        .rsp_redirect (rsp_redirect),
        .rsp_target   (rsp_target)
    );

endmodule

//--- source/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  csr_pkg::csr_cmd_e   req_cmd,
    input  csr_pkg::xlen_t      req_pc,
    input  logic                illegal,
    input  csr_pkg::priv_e      priv,
    input  logic                mstatus_mie,
    input  csr_pkg::xlen_t      mie_bits,
    input  csr_pkg::xlen_t      mip_bits,
    input  csr_pkg::xlen_t      mtvec,
    input  csr_pkg::xlen_t      mepc,
    output logic                take_trap,
    output csr_pkg::xlen_t      trap_cause,
    output logic                do_mret,
    output logic                rsp_valid,
    output logic                rsp_trap,
    output logic                rsp_redirect,
    output csr_pkg::xlen_t      rsp_target
);

    localparam logic [1:0] TVEC_VECTORED = 2'b01;

    logic           is_mret;
    logic           is_ecall;
    logic           bad_mret;
    logic           exc;
    csr_pkg::xlen_t exc_cause;
    csr_pkg::xlen_t pending;
    logic           irq_en;
    logic           take_irq;
    csr_pkg::xlen_t irq_cause;
    csr_pkg::xlen_t tvec_base;
    csr_pkg::xlen_t trap_target;
    csr_pkg::xlen_t next_target;

    assign is_mret  = req_valid && (req_cmd == csr_pkg::CMD_MRET);
    assign is_ecall = req_valid && (req_cmd == csr_pkg::CMD_ECALL);
    assign bad_mret = is_mret && (priv != csr_pkg::PRIV_M);

    // Exceptions first, then interrupts
    assign exc       = illegal || bad_mret || is_ecall;
    assign exc_cause = !is_ecall ? csr_pkg::CAUSE_ILLEGAL :
                       (priv == csr_pkg::PRIV_M) ? csr_pkg::CAUSE_ECALL_M :
                       csr_pkg::CAUSE_ECALL_U;

    // U-mode always takes M interrupts, M-mode only with MIE
    assign pending   = mip_bits & mie_bits;
    assign irq_en    = (priv == csr_pkg::PRIV_U) || mstatus_mie;
    assign take_irq  = req_valid && irq_en &&
                       (pending[csr_pkg::IRQ_MEI_BIT] || pending[csr_pkg::IRQ_MTI_BIT]);
    assign irq_cause = pending[csr_pkg::IRQ_MEI_BIT] ? csr_pkg::CAUSE_M_EXT
                                                     : csr_pkg::CAUSE_M_TIMER;

    assign take_trap  = exc || take_irq;
    assign trap_cause = exc ? exc_cause : irq_cause;
    assign do_mret    = is_mret && !take_trap;

    // Vectored mode offsets interrupts only
    assign tvec_base = {mtvec[31:2], 2'b00};
    always_comb begin
        if ((mtvec[1:0] == TVEC_VECTORED) && trap_cause[31]) begin
            trap_target = tvec_base + {trap_cause[29:0], 2'b00};
        end else begin
            trap_target = tvec_base;
        end
    end

    // No redirect means fall through to the next instruction
    assign next_target = take_trap ? trap_target :
                         do_mret   ? mepc        :
                         req_pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid    <= 1'b0;
            rsp_trap     <= 1'b0;
            rsp_redirect <= 1'b0;
        end else begin
            rsp_valid    <= req_valid;
            rsp_trap     <= take_trap;
            rsp_redirect <= take_trap || do_mret;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp_target <= next_target;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) rsp_redirect |-> rsp_valid)
        else $error("trap_ctrl: redirect without a valid response");

endmodule

//--- tests/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Expected outcome of one request
typedef struct packed {
    csr_pkg::xlen_t rdata;
    logic           check_rdata;
    logic           trap;
    logic           redirect;
    csr_pkg::xlen_t target;
    csr_pkg::priv_e priv;
} pred_t;

// Shadow copy of the architectural state, reset values
csr_pkg::priv_e m_mode      = csr_pkg::PRIV_M;
csr_pkg::priv_e m_mpp       = csr_pkg::PRIV_U;
logic           m_mie       = 1'b0;
logic           m_mpie      = 1'b0;
logic           m_irq_ext   = 1'b0;
logic           m_irq_timer = 1'b0;
csr_pkg::xlen_t m_ie        = '0;
csr_pkg::xlen_t m_tvec      = '0;
csr_pkg::xlen_t m_scratch   = '0;
csr_pkg::xlen_t m_epc       = '0;
csr_pkg::xlen_t m_cause     = '0;

function automatic logic is_counter(csr_pkg::csr_addr_t addr);
    return addr inside {csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MCYCLEH,
                        csr_pkg::ADDR_CYCLE, csr_pkg::ADDR_CYCLEH};
endfunction

function automatic logic is_known(csr_pkg::csr_addr_t addr);
    return is_counter(addr) ||
           addr inside {csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MISA, csr_pkg::ADDR_MIE,
                        csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MEPC,
                        csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MIP};
endfunction

// Counters are not modeled and read as zero here
function automatic csr_pkg::xlen_t model_read(csr_pkg::csr_addr_t addr);
    csr_pkg::xlen_t v;
    v = '0;
    case (addr)
        csr_pkg::ADDR_MSTATUS: begin
            v[3]     = m_mie;
            v[7]     = m_mpie;
            v[12:11] = m_mpp;
        end
        csr_pkg::ADDR_MISA:     v = csr_pkg::MISA_VALUE;
        csr_pkg::ADDR_MIE:      v = m_ie;
        csr_pkg::ADDR_MTVEC:    v = m_tvec;
        csr_pkg::ADDR_MSCRATCH: v = m_scratch;
        csr_pkg::ADDR_MEPC:     v = m_epc;
        csr_pkg::ADDR_MCAUSE:   v = m_cause;
        csr_pkg::ADDR_MIP: begin
            v[11] = m_irq_ext;
            v[7]  = m_irq_timer;
        end
        default: v = '0;
    endcase
    return v;
endfunction

// WARL fields keep legal values only
function automatic void model_write(csr_pkg::csr_addr_t addr, csr_pkg::xlen_t nv);
    case (addr)
        csr_pkg::ADDR_MSTATUS: begin
            m_mie  = nv[3];
            m_mpie = nv[7];
            m_mpp  = (nv[12:11] == 2'b11) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
        end
        csr_pkg::ADDR_MIE:      m_ie      = nv & 32'h0000_0880;
        csr_pkg::ADDR_MTVEC:    m_tvec    = nv & 32'hFFFF_FFFD;
        csr_pkg::ADDR_MSCRATCH: m_scratch = nv;
        csr_pkg::ADDR_MEPC:     m_epc     = nv & 32'hFFFF_FFFC;
        csr_pkg::ADDR_MCAUSE:   m_cause   = nv;
        default: ;
    endcase
endfunction

function automatic pred_t predict_response(csr_pkg::csr_cmd_e cmd, csr_pkg::csr_addr_t addr,
                                           csr_pkg::xlen_t operand, csr_pkg::xlen_t pc);
    pred_t          p;
    logic           is_csr;
    logic           bad;
    logic           exc;
    logic           irq_on;
    csr_pkg::xlen_t old;
    csr_pkg::xlen_t pend;
    csr_pkg::xlen_t cause;
    p      = '0;
    old    = model_read(addr);
    is_csr = (cmd == csr_pkg::CMD_W) || (cmd == csr_pkg::CMD_S) || (cmd == csr_pkg::CMD_C);
    bad    = (addr[9:8] > 2'(m_mode)) || (addr[11:10] == 2'b11) || !is_known(addr);
    exc    = (is_csr && bad) || (cmd == csr_pkg::CMD_ECALL) ||
             ((cmd == csr_pkg::CMD_MRET) && (m_mode != csr_pkg::PRIV_M));
    cause  = csr_pkg::CAUSE_ILLEGAL;
    if (cmd == csr_pkg::CMD_ECALL) begin
        cause = (m_mode == csr_pkg::PRIV_M) ? csr_pkg::CAUSE_ECALL_M : csr_pkg::CAUSE_ECALL_U;
    end
    pend     = '0;
    pend[11] = m_irq_ext & m_ie[11];
    pend[7]  = m_irq_timer & m_ie[7];
    irq_on   = (m_mode == csr_pkg::PRIV_U) || m_mie;
    if (!exc && irq_on && (pend != '0)) begin
        cause = pend[11] ? csr_pkg::CAUSE_M_EXT : csr_pkg::CAUSE_M_TIMER;
    end
    p.trap        = exc || (irq_on && (pend != '0));
    p.rdata       = old;
    p.check_rdata = is_csr && !p.trap && !is_counter(addr);
    if (p.trap) begin
        p.redirect = 1'b1;
        p.target   = m_tvec & 32'hFFFF_FFFC;
        // Vectored mode offsets interrupts by 4 times the code
        if ((m_tvec[1:0] == 2'b01) && cause[31]) begin
            p.target = p.target + ((cause & 32'h7FFF_FFFF) << 2);
        end
        m_epc   = pc;
        m_cause = cause;
        m_mpie  = m_mie;
        m_mie   = 1'b0;
        m_mpp   = m_mode;
        m_mode  = csr_pkg::PRIV_M;
    end else if (cmd == csr_pkg::CMD_MRET) begin
        p.redirect = 1'b1;
        p.target   = m_epc;
        m_mie      = m_mpie;
        m_mpie     = 1'b1;
        m_mode     = m_mpp;
        m_mpp      = csr_pkg::PRIV_U;
    end else if (is_csr) begin
        case (cmd)
            csr_pkg::CMD_W: model_write(addr, operand);
            csr_pkg::CMD_S: model_write(addr, old | operand);
            default:        model_write(addr, old & ~operand);
        endcase
    end
    p.priv = m_mode;
    return p;
endfunction

`endif

//--- tests/csr_stage_tb.sv
`timescale 1ns/1ps

module csr_stage_tb;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req_valid;
    csr_pkg::csr_cmd_e  req_cmd;
    csr_pkg::csr_addr_t req_addr;
    csr_pkg::xlen_t     req_operand;
    csr_pkg::xlen_t     req_pc;
    logic               irq_ext;
    logic               irq_timer;
    logic               rsp_valid;
    csr_pkg::xlen_t     rsp_rdata;
    logic               rsp_trap;
    logic               rsp_redirect;
    csr_pkg::xlen_t     rsp_target;
    csr_pkg::priv_e     priv;

    string              test_name = "reset";
    csr_pkg::xlen_t     lcg_state = 32'h484b;
    csr_pkg::xlen_t     cur_pc;
    int                 issued_count = 0;
    int                 rsp_count = 0;
    int                 first_idx;
    int                 second_idx;

    `include "csr_model.svh"

    pred_t              pred_q[$];
    pred_t              got;
    csr_pkg::xlen_t     rdata_log[$];
    logic               req_seen = 1'b0;

    csr_stage dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_cmd      (req_cmd),
        .req_addr     (req_addr),
        .req_operand  (req_operand),
        .req_pc       (req_pc),
        .irq_ext      (irq_ext),
        .irq_timer    (irq_timer),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .rsp_trap     (rsp_trap),
        .rsp_redirect (rsp_redirect),
        .rsp_target   (rsp_target),
        .priv         (priv)
    );

    always #2 clk = ~clk;

    function automatic csr_pkg::xlen_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(string what, csr_pkg::xlen_t exp, csr_pkg::xlen_t act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s: wrong %s", test_name, what);
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s: wrong %s", test_name, what);
        end
    endtask

    task automatic check_priv(string what, csr_pkg::priv_e exp, csr_pkg::priv_e act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s: wrong %s", test_name, what);
        end
    endtask

    // One request per call, back to back with the next call
    task automatic issue(csr_pkg::csr_cmd_e cmd, csr_pkg::csr_addr_t addr,
                         csr_pkg::xlen_t operand);
        req_valid   = 1'b1;
        req_cmd     = cmd;
        req_addr    = addr;
        req_operand = operand;
        req_pc      = cur_pc;
        pred_q.push_back(predict_response(cmd, addr, operand, cur_pc));
        issued_count++;
        cur_pc = cur_pc + 32'd4;
        @(posedge clk);
        #0.5;
    endtask

    // S with a zero operand reads without changing the value
    task automatic read_csr(csr_pkg::csr_addr_t addr);
        issue(csr_pkg::CMD_S, addr, '0);
    endtask

    task automatic exercise_rw(csr_pkg::csr_addr_t addr);
        issue(csr_pkg::CMD_W, addr, next_rand());
        read_csr(addr);
        issue(csr_pkg::CMD_S, addr, next_rand());
        read_csr(addr);
        issue(csr_pkg::CMD_C, addr, next_rand());
        read_csr(addr);
    endtask

    task automatic set_irq(logic ext, logic timer);
        irq_ext     = ext;
        irq_timer   = timer;
        m_irq_ext   = ext;
        m_irq_timer = timer;
    endtask

    task automatic drain_responses(int limit);
        int waited;
        waited = 0;
        while ((rsp_count != issued_count) && (waited < limit)) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        if (rsp_count != issued_count) begin
            $display("Timeout in %s: %0d responses for %0d requests", test_name,
                     rsp_count, issued_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "responses missing");
        end
    endtask

    task automatic finish_test();
        req_valid = 1'b0;
        req_cmd   = csr_pkg::CMD_NONE;
        @(posedge clk);
        #0.5;
        drain_responses(20);
    endtask

    // Request accepted on this edge, response due in the following cycle
    always @(posedge clk) begin
        req_seen <= req_valid;
    end

    // Responses are checked half a cycle after they appear
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag("rsp_valid", req_seen, rsp_valid);
        end
        if (rst_n && rsp_valid) begin
            if (pred_q.size() == 0) begin
                $display("Response in %s arrived with no request outstanding", test_name);
                $display("*** TEST FAILED ***");
                $fatal(1, "unexpected response");
            end else begin
                got = pred_q.pop_front();
                check_flag("rsp_trap", got.trap, rsp_trap);
                check_flag("rsp_redirect", got.redirect, rsp_redirect);
                check_priv("priv", got.priv, priv);
                if (got.check_rdata) begin
                    check_word("rsp_rdata", got.rdata, rsp_rdata);
                end
                if (got.redirect) begin
                    check_word("rsp_target", got.target, rsp_target);
                end
                rdata_log.push_back(rsp_rdata);
                rsp_count++;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_cmd     = csr_pkg::CMD_NONE;
        req_addr    = '0;
        req_operand = '0;
        req_pc      = '0;
        irq_ext     = 1'b0;
        irq_timer   = 1'b0;
        cur_pc      = 32'h0000_0100;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(posedge clk);
        #0.5;

        test_name = "reset";
        check_flag("rsp_valid", 1'b0, rsp_valid);
        check_flag("rsp_trap", 1'b0, rsp_trap);
        check_flag("rsp_redirect", 1'b0, rsp_redirect);
        check_priv("priv", csr_pkg::PRIV_M, priv);
        read_csr(csr_pkg::ADDR_MSTATUS);
        read_csr(csr_pkg::ADDR_MISA);
        read_csr(csr_pkg::ADDR_MIE);
        read_csr(csr_pkg::ADDR_MTVEC);
        read_csr(csr_pkg::ADDR_MSCRATCH);
        read_csr(csr_pkg::ADDR_MEPC);
        read_csr(csr_pkg::ADDR_MCAUSE);
        read_csr(csr_pkg::ADDR_MIP);
        finish_test();

        test_name = "csr_rw";
        exercise_rw(csr_pkg::ADDR_MSCRATCH);
        exercise_rw(csr_pkg::ADDR_MTVEC);
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_MEPC, next_rand());
        read_csr(csr_pkg::ADDR_MEPC);
        finish_test();

        // Drop to user mode, then try M-mode and read-only accesses
        test_name = "mret_user";
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_MTVEC, 32'h0000_1000);
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_MEPC, 32'h0000_0200);
        issue(csr_pkg::CMD_C, csr_pkg::ADDR_MSTATUS, 32'h0000_1800);
        issue(csr_pkg::CMD_MRET, csr_pkg::ADDR_MSCRATCH, '0);
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_MSCRATCH, 32'hA5A5_0F0F);
        read_csr(csr_pkg::ADDR_MCAUSE);
        issue(csr_pkg::CMD_MRET, csr_pkg::ADDR_MSCRATCH, '0);
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_CYCLE, next_rand());
        read_csr(csr_pkg::ADDR_MSCRATCH);
        read_csr(csr_pkg::ADDR_MEPC);
        finish_test();

        test_name = "ecall";
        issue(csr_pkg::CMD_S, csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        issue(csr_pkg::CMD_ECALL, csr_pkg::ADDR_MSCRATCH, '0);
        read_csr(csr_pkg::ADDR_MCAUSE);
        read_csr(csr_pkg::ADDR_MEPC);
        read_csr(csr_pkg::ADDR_MSTATUS);
        issue(csr_pkg::CMD_C, csr_pkg::ADDR_MSTATUS, 32'h0000_1800);
        issue(csr_pkg::CMD_MRET, csr_pkg::ADDR_MSCRATCH, '0);
        issue(csr_pkg::CMD_ECALL, csr_pkg::ADDR_MSCRATCH, '0);
        read_csr(csr_pkg::ADDR_MCAUSE);
        read_csr(csr_pkg::ADDR_MEPC);
        read_csr(csr_pkg::ADDR_MSTATUS);
        finish_test();

        // Vectored base 0x2000, external first, then timer
        test_name = "interrupts";
        set_irq(1'b1, 1'b1);
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_MTVEC, 32'h0000_2001);
        read_csr(csr_pkg::ADDR_MIP);
        issue(csr_pkg::CMD_W, csr_pkg::ADDR_MIE, 32'h0000_0880);
        issue(csr_pkg::CMD_S, csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        issue(csr_pkg::CMD_NONE, csr_pkg::ADDR_MSCRATCH, '0);
        read_csr(csr_pkg::ADDR_MCAUSE);
        issue(csr_pkg::CMD_C, csr_pkg::ADDR_MIE, 32'h0000_0800);
        issue(csr_pkg::CMD_S, csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        issue(csr_pkg::CMD_NONE, csr_pkg::ADDR_MSCRATCH, '0);
        issue(csr_pkg::CMD_NONE, csr_pkg::ADDR_MSCRATCH, '0);
        read_csr(csr_pkg::ADDR_MCAUSE);
        set_irq(1'b0, 1'b0);
        finish_test();

        test_name = "mcycle_delta";
        first_idx = issued_count;
        read_csr(csr_pkg::ADDR_MCYCLE);
        repeat (6) issue(csr_pkg::CMD_NONE, csr_pkg::ADDR_MSCRATCH, '0);
        second_idx = issued_count;
        read_csr(csr_pkg::ADDR_MCYCLE);
        finish_test();
        check_word("mcycle delta", 32'd7, rdata_log[second_idx] - rdata_log[first_idx]);

        if (pred_q.size() != 0) begin
            $display("%0d predicted responses never arrived", pred_q.size());
            $display("*** TEST FAILED ***");
            $fatal(1, "responses missing at the end");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
